//--- dsp_macros.svh
`ifndef DSP_MACROS_SVH
`define DSP_MACROS_SVH

// data path geometry
`define CHANNEL_WIDTH      4
`define CODE_PRECISION     8
`define FFE_LENGTH         3
`define WEIGHT_PRECISION   8
`define FFE_ACC_PRECISION  20
`define SHIFT_PRECISION    3
`define EST_DEPTH          2
`define EST_PRECISION      8

// wishbone side
`define WB_ADR_WIDTH       5
`define WB_DAT_WIDTH       8
`define REGS_PER_LANE      8

// field offsets inside one lane, address = lane*8 + offset
`define REG_W0             3'd0
`define REG_W1             3'd1
`define REG_W2             3'd2
`define REG_THRESH         3'd3
`define REG_FFE_SHIFT      3'd4
`define REG_MLSD_SHIFT     3'd5
`define REG_H0             3'd6
`define REG_H1             3'd7

`endif

//--- dsp_pkg.sv
`include "dsp_macros.svh"

package dsp_pkg;

	typedef logic signed [`CODE_PRECISION-1:0]    code_t;
	typedef logic signed [`WEIGHT_PRECISION-1:0]  weight_t;
	typedef logic signed [`EST_PRECISION-1:0]     est_t;
	typedef logic signed [`CODE_PRECISION-1:0]    thresh_t; // compared against estimates
	typedef logic        [`SHIFT_PRECISION-1:0]   shift_t;
	typedef logic signed [`FFE_ACC_PRECISION-1:0] acc_t;
	typedef logic        [`WB_DAT_WIDTH-1:0]      wb_dat_t;
	typedef logic        [`WB_ADR_WIDTH-1:0]      wb_adr_t;

	// lane 0 is the oldest symbol of the block
	typedef struct packed {
		code_t [`CHANNEL_WIDTH-1:0] lane;
	} code_blk_t;

	typedef logic [`CHANNEL_WIDTH-1:0] bit_blk_t;

	typedef struct packed {
		weight_t w0;
		weight_t w1;
		weight_t w2;
		thresh_t thresh;
		shift_t  ffe_shift;
		shift_t  mlsd_shift;
		est_t    h0;
		est_t    h1;
	} lane_cfg_t;

	typedef lane_cfg_t [`CHANNEL_WIDTH-1:0] cfg_bank_t;

	typedef struct packed {
		logic    cyc;
		logic    stb;
		logic    we;
		wb_adr_t adr;
		wb_dat_t dat;
	} wb_req_t;

	typedef struct packed {
		logic    ack;
		wb_dat_t dat;
	} wb_rsp_t;

	typedef enum logic {
		WB_IDLE = 1'b0,
		WB_ACK  = 1'b1
	} wb_state_e;

endpackage

//--- code_buffer.sv
module code_buffer #(
	parameter int DEPTH = 3
) (
	input  logic                            clk,
	input  logic                            rstb,
	input  dsp_pkg::code_blk_t              in_i,
	output dsp_pkg::code_blk_t [DEPTH-1:0]  buffer_o
);

	// stage 0 is the newest block, stage DEPTH-1 the oldest
	always_ff @(posedge clk) begin
		if (!rstb) begin
			buffer_o <= '0;
		end else begin
			buffer_o[0] <= in_i;
			for (int i = 1; i < DEPTH; i++) begin
				buffer_o[i] <= buffer_o[i-1]; // shift one block older
			end
		end
	end

endmodule

//--- dsp_config_regs.sv
`include "dsp_macros.svh"

module dsp_config_regs (
	input  logic               clk,
	input  logic               rstb,
	input  dsp_pkg::wb_req_t   wb_req_i,
	output dsp_pkg::wb_rsp_t   wb_rsp_o,
	output dsp_pkg::cfg_bank_t cfg_o
);
	import dsp_pkg::*;

	localparam int OFS_W  = $clog2(`REGS_PER_LANE);
	localparam int LANE_W = $clog2(`CHANNEL_WIDTH);

	wb_state_e         state_q;
	logic [LANE_W-1:0] lane;
	logic [OFS_W-1:0]  ofs;
	logic              req;
	wb_dat_t           wdat;
	wb_dat_t           rdat;

	assign lane = wb_req_i.adr[OFS_W +: LANE_W];
	assign ofs  = wb_req_i.adr[OFS_W-1:0];
	assign req  = wb_req_i.cyc && wb_req_i.stb;
	assign wdat = wb_req_i.dat;

	// idle -> ack for one cycle -> idle
	always_ff @(posedge clk) begin
		if (!rstb) begin
			state_q <= WB_IDLE;
		end else begin
			case (state_q)
				WB_IDLE: begin
					if (req) begin
						state_q <= WB_ACK;
					end
				end
				default: state_q <= WB_IDLE;
			endcase
		end
	end

	// write lands on the same edge that raises ack
	always_ff @(posedge clk) begin
		if (!rstb) begin
			cfg_o <= '0;
		end else if (state_q == WB_IDLE && req && wb_req_i.we) begin
			case (ofs)
				`REG_W0:         cfg_o[lane].w0         <= wdat;
				`REG_W1:         cfg_o[lane].w1         <= wdat;
				`REG_W2:         cfg_o[lane].w2         <= wdat;
				`REG_THRESH:     cfg_o[lane].thresh     <= wdat;
				`REG_FFE_SHIFT:  cfg_o[lane].ffe_shift  <= wdat[`SHIFT_PRECISION-1:0];
				`REG_MLSD_SHIFT: cfg_o[lane].mlsd_shift <= wdat[`SHIFT_PRECISION-1:0];
				`REG_H0:         cfg_o[lane].h0         <= wdat;
				`REG_H1:         cfg_o[lane].h1         <= wdat;
			endcase
		end
	end

	// read data follows adr while ack is high
	always_comb begin
		case (ofs)
			`REG_W0:         rdat = cfg_o[lane].w0;
			`REG_W1:         rdat = cfg_o[lane].w1;
			`REG_W2:         rdat = cfg_o[lane].w2;
			`REG_THRESH:     rdat = cfg_o[lane].thresh;
			`REG_FFE_SHIFT:  rdat = wb_dat_t'(cfg_o[lane].ffe_shift);  // zero ext
			`REG_MLSD_SHIFT: rdat = wb_dat_t'(cfg_o[lane].mlsd_shift);
			`REG_H0:         rdat = cfg_o[lane].h0;
			`REG_H1:         rdat = cfg_o[lane].h1;
			default:         rdat = '0;
		endcase
	end

	assign wb_rsp_o.ack = (state_q == WB_ACK);
	assign wb_rsp_o.dat = rdat;

endmodule

//--- comb_ffe.sv
`include "dsp_macros.svh"

module comb_ffe (
	input  dsp_pkg::code_blk_t cur_i,
	input  dsp_pkg::code_blk_t prev_i,
	input  dsp_pkg::cfg_bank_t cfg_i,
	output dsp_pkg::code_blk_t est_o
);
	import dsp_pkg::*;

	localparam acc_t CODE_MAX = acc_t'((1 << (`CODE_PRECISION-1)) - 1);
	localparam acc_t CODE_MIN = -CODE_MAX - acc_t'(1);

	// symbol stream over two blocks, previous block in the low half
	code_t [2*`CHANNEL_WIDTH-1:0] sym;

	assign sym = {cur_i.lane, prev_i.lane};

	function automatic code_t saturate(input acc_t v);
		if (v > CODE_MAX) begin
			return code_t'(CODE_MAX);
		end else if (v < CODE_MIN) begin
			return code_t'(CODE_MIN);
		end
		return code_t'(v);
	endfunction

	always_comb begin
		acc_t                       acc;
		weight_t [`FFE_LENGTH-1:0] w;
		for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
			w   = {cfg_i[i].w2, cfg_i[i].w1, cfg_i[i].w0};
			acc = '0;
			// tap j looks j symbols back, may reach into prev block
			for (int j = 0; j < `FFE_LENGTH; j++) begin
				acc = acc + acc_t'(w[j]) * acc_t'(sym[`CHANNEL_WIDTH + i - j]);
			end
			est_o.lane[i] = saturate(acc >>> cfg_i[i].ffe_shift);
		end
	end

endmodule

//--- comb_mlsd_decision.sv
`include "dsp_macros.svh"

module comb_mlsd_decision (
	input  dsp_pkg::code_blk_t codes_i,
	input  dsp_pkg::bit_blk_t  bits_i,
	input  logic               prev_bit_i,
	input  dsp_pkg::cfg_bank_t cfg_i,
	output dsp_pkg::bit_blk_t  checked_o
);
	import dsp_pkg::*;

	// room for |h0| + |h1| and the difference to a code
	typedef logic signed [`EST_PRECISION+2:0] wide_t;

	bit_blk_t prev_chain;  // b[n-1] for each lane

	assign prev_chain = {bits_i[`CHANNEL_WIDTH-2:0], prev_bit_i};

	// tap k weighs bit b[n-k], +h for a one and -h for a zero
	function automatic wide_t expected(
		input est_t [`EST_DEPTH-1:0] h,
		input logic [`EST_DEPTH-1:0] sgn,
		input shift_t                sh
	);
		wide_t sum;
		sum = '0;
		for (int k = 0; k < `EST_DEPTH; k++) begin
			if (sgn[k]) begin
				sum = sum + wide_t'(h[k]);
			end else begin
				sum = sum - wide_t'(h[k]);
			end
		end
		return sum >>> sh;
	endfunction

	function automatic wide_t abs_diff(input code_t c, input wide_t e);
		wide_t d;
		d = wide_t'(c) - e;
		return (d < 0) ? -d : d;
	endfunction

	always_comb begin
		est_t [`EST_DEPTH-1:0] h;
		wide_t                 err_p;
		wide_t                 err_n;
		for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
			h     = {cfg_i[i].h1, cfg_i[i].h0};
			err_p = abs_diff(codes_i.lane[i],
				expected(h, {prev_chain[i], 1'b1}, cfg_i[i].mlsd_shift));
			err_n = abs_diff(codes_i.lane[i],
				expected(h, {prev_chain[i], 1'b0}, cfg_i[i].mlsd_shift));
			if (err_p < err_n) begin
				checked_o[i] = 1'b1;
			end else if (err_p > err_n) begin
				checked_o[i] = 1'b0;
			end else begin
				checked_o[i] = bits_i[i]; // tie keeps slicer bit
			end
		end
	end

endmodule

//--- dsp_backend.sv
`include "dsp_macros.svh"

module dsp_backend (
	input  logic               clk,
	input  logic               rstb,
	input  dsp_pkg::code_blk_t codes_i,
	input  dsp_pkg::wb_req_t   wb_req_i,
	output dsp_pkg::wb_rsp_t   wb_rsp_o,
	output dsp_pkg::code_blk_t estimated_o,
	output dsp_pkg::bit_blk_t  checked_o
);
	import dsp_pkg::*;

	localparam int BUF_DEPTH = 3;

	code_blk_t [BUF_DEPTH-1:0] code_buf;
	cfg_bank_t                 cfg;
	code_blk_t                 est_comb;
	bit_blk_t                  slice_comb;
	bit_blk_t                  slice_q;
	bit_blk_t                  checked_comb;
	logic                      prev_bit_q;  // lane 3 slicer bit of the block before

	code_buffer #(
		.DEPTH    (BUF_DEPTH)
	) code_buf_i (
		.clk      (clk),
		.rstb     (rstb),
		.in_i     (codes_i),
		.buffer_o (code_buf)
	);

	dsp_config_regs cfg_i (
		.clk      (clk),
		.rstb     (rstb),
		.wb_req_i (wb_req_i),
		.wb_rsp_o (wb_rsp_o),
		.cfg_o    (cfg)
	);

	comb_ffe cffe_i (
		.cur_i  (code_buf[0]),
		.prev_i (code_buf[1]),
		.cfg_i  (cfg),
		.est_o  (est_comb)
	);

	always_ff @(posedge clk) begin
		if (!rstb) begin
			estimated_o <= '0;
		end else begin
			estimated_o <= est_comb;
		end
	end

	// signed compare, equal to threshold slices to one
	always_comb begin
		for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
			slice_comb[i] = (estimated_o.lane[i] >= cfg[i].thresh);
		end
	end

	always_ff @(posedge clk) begin
		if (!rstb) begin
			slice_q    <= '0;
			prev_bit_q <= 1'b0;
		end else begin
			slice_q    <= slice_comb;
			prev_bit_q <= slice_q[`CHANNEL_WIDTH-1];
		end
	end

	// stage 2 lines up with the slicer bits of the same block
	comb_mlsd_decision comb_mlsd_dec_i (
		.codes_i    (code_buf[BUF_DEPTH-1]),
		.bits_i     (slice_q),
		.prev_bit_i (prev_bit_q),
		.cfg_i      (cfg),
		.checked_o  (checked_comb)
	);

	always_ff @(posedge clk) begin
		if (!rstb) begin
			checked_o <= '0;
		end else begin
			checked_o <= checked_comb;
		end
	end

endmodule

//--- dsp_backend_sva.sv
module dsp_backend_sva (
	input logic             clk,
	input logic             rstb,
	input dsp_pkg::wb_req_t wb_req_i,
	input dsp_pkg::wb_rsp_t wb_rsp_i
);
	timeunit 1ns;
	timeprecision 1ps;

	logic req;

	assign req = wb_req_i.cyc && wb_req_i.stb;

	ack_one_cycle: assert property (@(posedge clk) disable iff (!rstb)
		wb_rsp_i.ack |=> !wb_rsp_i.ack)
		else $error("ack held for more than one cycle");

	// slave only answers a request seen on the edge before
	ack_after_req: assert property (@(posedge clk) disable iff (!rstb)
		wb_rsp_i.ack |-> $past(req))
		else $error("ack without a request in the cycle before");

	ack_low_in_reset: assert property (@(posedge clk)
		!rstb |=> !wb_rsp_i.ack)
		else $error("ack high after a reset cycle");

endmodule

bind dsp_config_regs dsp_backend_sva dsp_backend_sva_i (
	.clk      (clk),
	.rstb     (rstb),
	.wb_req_i (wb_req_i),
	.wb_rsp_i (wb_rsp_o)
);

//--- dsp_backend_tb.sv
`include "dsp_macros.svh"

module dsp_backend_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import dsp_pkg::*;

	localparam int NROWS   = 6;
	localparam int NFIXED  = 3;  // hand written rows, the rest random
	localparam int NBLK    = 8;
	localparam int NFIELDS = `CHANNEL_WIDTH * `REGS_PER_LANE;
	// blocks plus bus cycles per row, doubled for margin
	localparam int CYCLES      = NROWS * (4 * NFIELDS + NBLK + 6) + 40;
	localparam int WATCHDOG_NS = CYCLES * 10 * 2;

	logic      clk;
	logic      rstb;
	code_blk_t codes;
	wb_req_t   wb_req;
	wb_rsp_t   wb_rsp;
	code_blk_t estimated;
	bit_blk_t  checked;
	integer    seed = 57307;
	int        err_est = 0;
	int        err_chk = 0;
	int        err_wb = 0;
	int        err_other = 0;

	cfg_bank_t row_cfg [NROWS];
	code_blk_t row_blk [NROWS][NBLK];
	code_blk_t exp_est [NROWS][NBLK];
	bit_blk_t  exp_chk [NROWS][NBLK];

	dsp_backend dsp_backend_i (
		.clk         (clk),
		.rstb        (rstb),
		.codes_i     (codes),
		.wb_req_i    (wb_req),
		.wb_rsp_o    (wb_rsp),
		.estimated_o (estimated),
		.checked_o   (checked)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
		$display("Test failed");
		$finish;
	end

	function automatic int sx(input logic [7:0] v);
		return int'($signed(v));
	endfunction

	function automatic code_blk_t blk(input int l0, l1, l2, l3);
		return '{lane: {code_t'(l3), code_t'(l2), code_t'(l1), code_t'(l0)}};
	endfunction

	function automatic lane_cfg_t lcfg(input int w0, w1, w2, th, fs, ms, h0, h1);
		return '{weight_t'(w0), weight_t'(w1), weight_t'(w2), thresh_t'(th),
			shift_t'(fs), shift_t'(ms), est_t'(h0), est_t'(h1)};
	endfunction

	// register map, shift fields read back zero extended
	function automatic wb_dat_t field_of(input cfg_bank_t cfg, input int lane, input int ofs);
		case (ofs)
			`REG_W0:         return cfg[lane].w0;
			`REG_W1:         return cfg[lane].w1;
			`REG_W2:         return cfg[lane].w2;
			`REG_THRESH:     return cfg[lane].thresh;
			`REG_FFE_SHIFT:  return wb_dat_t'(cfg[lane].ffe_shift);
			`REG_MLSD_SHIFT: return wb_dat_t'(cfg[lane].mlsd_shift);
			`REG_H0:         return cfg[lane].h0;
			default:         return cfg[lane].h1;
		endcase
	endfunction

	function automatic code_blk_t model_est(input cfg_bank_t cfg, input code_blk_t cur,
		input code_blk_t prev);
		code_blk_t e;
		int        acc;
		int        c;
		int        w [3];
		for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
			w[0] = sx(cfg[i].w0);
			w[1] = sx(cfg[i].w1);
			w[2] = sx(cfg[i].w2);
			acc  = 0;
			for (int j = 0; j < 3; j++) begin
				if (i - j >= 0) begin
					c = sx(cur.lane[i-j]);
				end else begin
					c = sx(prev.lane[`CHANNEL_WIDTH+i-j]); // tail of the block before
				end
				acc += w[j] * c;
			end
			acc = acc >>> cfg[i].ffe_shift;
			if (acc > 127) begin
				acc = 127;
			end else if (acc < -128) begin
				acc = -128;
			end
			e.lane[i] = code_t'(acc);
		end
		return e;
	endfunction

	function automatic bit_blk_t model_slice(input cfg_bank_t cfg, input code_blk_t est);
		bit_blk_t b;
		for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
			b[i] = sx(est.lane[i]) >= sx(cfg[i].thresh);
		end
		return b;
	endfunction

	function automatic bit_blk_t model_check(input cfg_bank_t cfg, input code_blk_t cur,
		input bit_blk_t bits, input logic prev_bit);
		bit_blk_t r;
		logic     pb;
		int       s;
		int       dp;
		int       dn;
		for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
			if (i == 0) begin
				pb = prev_bit;
			end else begin
				pb = bits[i-1];
			end
			s  = pb ? 1 : -1;
			dp = sx(cur.lane[i]) - ((sx(cfg[i].h0) + s * sx(cfg[i].h1)) >>> cfg[i].mlsd_shift);
			dn = sx(cur.lane[i]) - ((-sx(cfg[i].h0) + s * sx(cfg[i].h1)) >>> cfg[i].mlsd_shift);
			dp = (dp < 0) ? -dp : dp;
			dn = (dn < 0) ? -dn : dn;
			if (dp < dn) begin
				r[i] = 1'b1;
			end else if (dp > dn) begin
				r[i] = 1'b0;
			end else begin
				r[i] = bits[i];
			end
		end
		return r;
	endfunction

	task automatic build_expected(input int r);
		code_blk_t prev;
		bit_blk_t  bits;
		logic      pb;
		prev = '0;
		bits = model_slice(row_cfg[r], prev); // zero blocks stream ahead of each row
		for (int k = 0; k < NBLK; k++) begin
			pb            = bits[`CHANNEL_WIDTH-1];
			exp_est[r][k] = model_est(row_cfg[r], row_blk[r][k], prev);
			bits          = model_slice(row_cfg[r], exp_est[r][k]);
			exp_chk[r][k] = model_check(row_cfg[r], row_blk[r][k], bits, pb);
			prev          = row_blk[r][k];
		end
	endtask

	task automatic load_table();
		// FFE: identity, mixed taps, saturation, shifted taps
		row_cfg[0][0] = lcfg(1, 0, 0, 0, 0, 0, 0, 0);
		row_cfg[0][1] = lcfg(2, -1, 1, 0, 1, 0, 0, 0);
		row_cfg[0][2] = lcfg(100, 100, 100, 0, 0, 0, 0, 0);
		row_cfg[0][3] = lcfg(-3, 5, 2, 0, 2, 0, 0, 0);
		row_blk[0] = '{blk(10, -20, 30, -40), blk(127, 127, 127, 127),
			blk(-128, -128, -128, -128), blk(1, -1, 2, -2), blk(5, 60, -70, 90),
			blk(0, 0, 0, 0), blk(-100, 50, -25, 12), blk(64, -64, 32, -32)};
		// slicer thresholds with h0 = h1 = 0
		row_cfg[1][0] = lcfg(1, 0, 0, 0, 0, 0, 0, 0);
		row_cfg[1][1] = lcfg(1, 0, 0, 10, 0, 0, 0, 0);
		row_cfg[1][2] = lcfg(1, 0, 0, -5, 0, 0, 0, 0);
		row_cfg[1][3] = lcfg(1, 0, 0, 100, 0, 0, 0, 0);
		row_blk[1] = '{blk(0, 10, -5, 100), blk(-1, 9, -6, 99), blk(1, 11, -4, 101),
			blk(-128, 127, -128, 127), blk(50, -50, 0, 120), blk(0, 0, 0, 0),
			blk(-2, 20, -5, -100), blk(3, 10, -10, 100)};
		// checker overrides
		row_cfg[2][0] = lcfg(1, 0, 0, 0, 0, 0, 40, 20);
		row_cfg[2][1] = lcfg(1, 0, 0, 0, 0, 1, 40, 20);
		row_cfg[2][2] = lcfg(1, 0, 0, 0, 0, 0, -30, 10);
		row_cfg[2][3] = lcfg(1, 0, 0, 0, 0, 2, 60, -20);
		row_blk[2] = '{blk(15, 25, -5, 30), blk(-15, 20, -25, 10), blk(50, -10, 5, -60),
			blk(0, 15, -20, 25), blk(22, -18, 12, -8), blk(60, -60, 40, -40),
			blk(-3, 3, -7, 7), blk(18, -22, 16, -4)};
		for (int r = NFIXED; r < NROWS; r++) begin
			for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
				row_cfg[r][i] = lcfg($random(seed), $random(seed), $random(seed),
					$random(seed), $random(seed), $random(seed), $random(seed),
					$random(seed));
			end
			for (int k = 0; k < NBLK; k++) begin
				row_blk[r][k] = code_blk_t'($random(seed));
			end
		end
		for (int r = 0; r < NROWS; r++) begin
			build_expected(r);
		end
	endtask

	task automatic check_code(input code_blk_t got, input code_blk_t exp, input string what);
		if (got !== exp) begin
			err_est++;
			$display("FAIL %0t: %s estimate %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_bits(input bit_blk_t got, input bit_blk_t exp, input string what);
		if (got !== exp) begin
			err_chk++;
			$display("FAIL %0t: %s checked bits %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_wb(input wb_dat_t got, input wb_dat_t exp, input wb_adr_t adr);
		if (got !== exp) begin
			err_wb++;
			$display("FAIL %0t: read of address %0d gave %h, expected %h", $time, adr, got, exp);
		end
	endtask

	// called 1 ns after an edge, returns 1 ns after the edge ending the transfer
	task automatic bus_cycle(input logic we, input wb_adr_t adr, input wb_dat_t wdat,
		output wb_dat_t rdat);
		int waited;
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
		waited = 0;
		do begin
			@(posedge clk);
			#1;
			waited++;
		end while (!wb_rsp.ack && waited < 8);
		if (!wb_rsp.ack) begin
			err_other++;
			$display("no ack for the transfer to address %0d", adr);
		end
		rdat   = wb_rsp.dat;
		wb_req = '0;
		@(posedge clk);
		#1;
		if (wb_rsp.ack) begin
			err_other++;
			$display("ack stayed high for a second cycle at address %0d", adr);
		end
	endtask

	task automatic wb_write(input wb_adr_t adr, input wb_dat_t wdat);
		wb_dat_t unused;
		bus_cycle(1'b1, adr, wdat, unused);
	endtask

	task automatic wb_read(input wb_adr_t adr, output wb_dat_t rdat);
		bus_cycle(1'b0, adr, '0, rdat);
	endtask

	task automatic apply_row(input int r);
		wb_dat_t rd;
		wb_adr_t adr;
		for (int a = 0; a < NFIELDS; a++) begin
			wb_write(wb_adr_t'(a), field_of(row_cfg[r], a / `REGS_PER_LANE, a % `REGS_PER_LANE));
		end
		for (int a = 0; a < NFIELDS; a++) begin
			adr = wb_adr_t'(a);
			wb_read(adr, rd);
			check_wb(rd, field_of(row_cfg[r], a / `REGS_PER_LANE, a % `REGS_PER_LANE), adr);
		end
		// estimate 2 edges, checked bits 4 edges after a block is sampled
		for (int s = 0; s < NBLK + 4; s++) begin
			@(posedge clk);
			#1;
			if (s >= 2 && s - 2 < NBLK) begin
				check_code(estimated, exp_est[r][s-2], $sformatf("row %0d block %0d", r, s - 2));
			end
			if (s >= 4) begin
				check_bits(checked, exp_chk[r][s-4], $sformatf("row %0d block %0d", r, s - 4));
			end
			codes = (s < NBLK) ? row_blk[r][s] : '0;
		end
	endtask

	initial begin
		wb_dat_t   rd;
		cfg_bank_t zero_cfg;
		bit_blk_t  idle_bits;
		rstb     = 1'b0;
		codes    = '0;
		wb_req   = '0;
		zero_cfg = '0;
		load_table();
		repeat (5) @(posedge clk);
		#1;
		rstb = 1'b1;
		@(posedge clk);
		#1;
		check_code(estimated, '0, "after reset");
		check_bits(checked, '0, "after reset");
		if (wb_rsp.ack) begin
			err_other++;
			$display("ack seen right after reset");
		end
		repeat (3) @(posedge clk);
		#1;
		idle_bits = model_slice(zero_cfg, '0);
		check_bits(checked, model_check(zero_cfg, '0, idle_bits, idle_bits[`CHANNEL_WIDTH-1]),
			"zero config idle stream");
		// unused high bits of a shift field
		wb_write(wb_adr_t'(`REGS_PER_LANE + `REG_FFE_SHIFT), 8'hFD);
		wb_read(wb_adr_t'(`REGS_PER_LANE + `REG_FFE_SHIFT), rd);
		check_wb(rd, 8'hFD & 8'h07, wb_adr_t'(`REGS_PER_LANE + `REG_FFE_SHIFT));
		for (int r = 0; r < NROWS; r++) begin
			apply_row(r);
		end
		$display("errors: estimate %0d, checked %0d, wishbone %0d, other %0d",
			err_est, err_chk, err_wb, err_other);
		if (err_est + err_chk + err_wb + err_other == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- all.f
+incdir+.
dsp_pkg.sv
code_buffer.sv
dsp_config_regs.sv
comb_ffe.sv
comb_mlsd_decision.sv
dsp_backend.sv
dsp_backend_sva.sv
dsp_backend_tb.sv

//--- run.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module dsp_backend_tb -f all.f --Mdir obj_dir -o dsp_backend_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/dsp_backend_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -qx "Test passed" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
